//--- design/board_pkg.sv
package board_pkg;

    // width of a reset phase length
    localparam int TIMER_W = 16;

    // reset phase length or remaining count
    typedef logic [TIMER_W-1:0] rst_cnt_t;

    // number of video frames, sets the led blink rate
    typedef logic [7:0] frame_cnt_t;

    // led request from the game
    // bit 0 lights the led steadily
    // bit 1 asks for a blink to get attention
    typedef logic [1:0] game_led_t;

    // reset phases in the order they normally run
    // ST_ROM_LOAD holds the game in reset while a rom is downloaded
    typedef enum logic [2:0] {
        ST_WAIT_LOCK,
        ST_SDRAM_INIT,
        ST_SYS_RST,
        ST_GAME_RST,
        ST_RUN,
        ST_ROM_LOAD
    } reset_state_t;

endpackage

//--- design/reset_timer.sv
`timescale 1ns/1ps

module reset_timer import board_pkg::*; (
    input  logic     clk_rom,
    input  logic     rst_n,
    input  logic     load,
    input  rst_cnt_t length,
    output logic     done
);

    rst_cnt_t count;

    // the count takes the new length at the edge that sees load,
    // so the first cycle of the phase already holds the full length
    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= length;
        end else if (count != '0) begin
            count <= count - rst_cnt_t'(1);
        end
    end

    // count of one is the last cycle of the loaded length
    // zero means idle, which also reads as done
    assign done = (count[TIMER_W-1:1] == '0);

endmodule

//--- design/reset_fsm.sv
`timescale 1ns/1ps

module reset_fsm import board_pkg::*; #(
    parameter rst_cnt_t INIT_CYCLES     = 16'd64,
    parameter rst_cnt_t SYS_RST_CYCLES  = 16'd16,
    parameter rst_cnt_t GAME_RST_CYCLES = 16'd32
) (
    input  logic     clk_rom,
    input  logic     rst_n,
    input  logic     pll_locked,
    input  logic     rst_req,
    input  logic     soft_rst,
    input  logic     dwnld_busy,
    input  logic     ioctl_wr,
    input  logic     ioctl_cart,
    input  logic     timer_done,
    output logic     timer_load,
    output rst_cnt_t timer_length,
    output logic     sdram_init,
    output logic     rst,
    output logic     game_rst
);

    reset_state_t state;
    reset_state_t state_nxt;
    logic         rom_wr;
    logic         after_init;
    logic         game_phase;

    // any download write that is not cartridge data resets the game
    assign rom_wr = ioctl_wr & dwnld_busy & ~ioctl_cart;

    // states past the sdram initialisation, where requests are honoured
    assign after_init = (state == ST_SYS_RST) || (state == ST_GAME_RST) ||
                        (state == ST_RUN) || (state == ST_ROM_LOAD);

    // soft reset only touches a running or resetting game
    assign game_phase = (state == ST_RUN) || (state == ST_GAME_RST);

    always_comb begin
        state_nxt    = state;
        timer_load   = 1'b0;
        timer_length = '0;
        if (!pll_locked) begin
            // lock loss beats everything
            state_nxt = ST_WAIT_LOCK;
        end else if (rom_wr && after_init) begin
            // a rom write wins over a reset request in the same cycle
            // and keeps the machine in ST_ROM_LOAD if already there
            state_nxt = ST_ROM_LOAD;
        end else if (rst_req && after_init) begin
            state_nxt    = ST_SYS_RST;
            timer_load   = 1'b1;
            timer_length = SYS_RST_CYCLES;
        end else if (soft_rst && game_phase) begin
            // restart the game phase, even from inside it
            state_nxt    = ST_GAME_RST;
            timer_load   = 1'b1;
            timer_length = GAME_RST_CYCLES;
        end else begin
            case (state)
                ST_WAIT_LOCK: begin
                    state_nxt    = ST_SDRAM_INIT;
                    timer_load   = 1'b1;
                    timer_length = INIT_CYCLES;
                end
                ST_SDRAM_INIT: begin
                    if (timer_done) begin
                        state_nxt    = ST_SYS_RST;
                        timer_load   = 1'b1;
                        timer_length = SYS_RST_CYCLES;
                    end
                end
                ST_SYS_RST: begin
                    if (timer_done) begin
                        state_nxt    = ST_GAME_RST;
                        timer_load   = 1'b1;
                        timer_length = GAME_RST_CYCLES;
                    end
                end
                ST_GAME_RST: begin
                    if (timer_done) begin
                        state_nxt = ST_RUN;
                    end
                end
                ST_RUN: begin
                    state_nxt = ST_RUN;
                end
                ST_ROM_LOAD: begin
                    // download over, the game gets a full reset phase
                    if (!dwnld_busy) begin
                        state_nxt    = ST_GAME_RST;
                        timer_load   = 1'b1;
                        timer_length = GAME_RST_CYCLES;
                    end
                end
                default: begin
                    state_nxt = ST_WAIT_LOCK;
                end
            endcase
        end
    end

    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            state <= ST_WAIT_LOCK;
        end else begin
            state <= state_nxt;
        end
    end

    // each output covers the ones before it, so ordering holds by construction
    assign sdram_init = (state == ST_WAIT_LOCK) || (state == ST_SDRAM_INIT);
    assign rst        = sdram_init || (state == ST_SYS_RST);
    assign game_rst   = rst || (state == ST_GAME_RST) || (state == ST_ROM_LOAD);

endmodule

//--- design/led_driver.sv
`timescale 1ns/1ps

module led_driver import board_pkg::*; #(
    parameter frame_cnt_t BLINK_FRAMES = 8'd4
) (
    input  logic      clk_rom,
    input  logic      rst_n,
    input  logic      rst,
    input  logic      lvbl,
    input  logic      dwnld_busy,
    input  logic      osd_shown,
    input  game_led_t game_led,
    output logic      led
);

    logic       lvbl_q;
    logic       frame_edge;
    logic       blink;
    logic       blink_q;
    frame_cnt_t frame_cnt;
    frame_cnt_t frame_cnt_nxt;

    // falling edge of lvbl, flagged one cycle after lvbl is seen low
    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            lvbl_q     <= 1'b0;
            frame_edge <= 1'b0;
        end else begin
            lvbl_q     <= lvbl;
            frame_edge <= lvbl_q & ~lvbl;
        end
    end

    // download activity or a game request both blink
    assign blink         = dwnld_busy | game_led[1];
    assign frame_cnt_nxt = frame_cnt + frame_cnt_t'(1);

    always_ff @(posedge clk_rom) begin
        if (!rst_n || rst) begin
            led       <= 1'b0;
            blink_q   <= 1'b0;
            frame_cnt <= '0;
        end else begin
            blink_q <= blink;
            if (!blink) begin
                // steady modes, osd first
                frame_cnt <= '0;
                led       <= osd_shown | game_led[0];
            end else if (!blink_q) begin
                // new blink phase starts lit
                // a frame edge in this cycle is not counted
                frame_cnt <= '0;
                led       <= 1'b1;
            end else if (frame_edge) begin
                if (frame_cnt_nxt >= BLINK_FRAMES) begin
                    frame_cnt <= '0;
                    led       <= ~led;
                end else begin
                    frame_cnt <= frame_cnt_nxt;
                end
            end
        end
    end

endmodule

//--- design/board_supervisor.sv
`timescale 1ns/1ps

module board_supervisor import board_pkg::*; #(
    parameter rst_cnt_t   INIT_CYCLES     = 16'd64,
    parameter rst_cnt_t   SYS_RST_CYCLES  = 16'd16,
    parameter rst_cnt_t   GAME_RST_CYCLES = 16'd32,
    parameter frame_cnt_t BLINK_FRAMES    = 8'd4
) (
    input  logic      clk_rom,
    input  logic      rst_n,
    input  logic      pll_locked,
    input  logic      rst_req,
    input  logic      soft_rst,
    input  logic      dwnld_busy,
    input  logic      ioctl_wr,
    input  logic      ioctl_cart,
    input  logic      lvbl,
    input  logic      osd_shown,
    input  game_led_t game_led,
    output logic      sdram_init,
    output logic      rst,
    output logic      game_rst,
    output logic      led
);

    logic     timer_load;
    rst_cnt_t timer_length;
    logic     timer_done;

    // one timer serves every reset phase
    reset_timer u_timer (
        .clk_rom    ( clk_rom      ),
        .rst_n      ( rst_n        ),
        .load       ( timer_load   ),
        .length     ( timer_length ),
        .done       ( timer_done   )
    );

    reset_fsm #(
        .INIT_CYCLES     ( INIT_CYCLES     ),
        .SYS_RST_CYCLES  ( SYS_RST_CYCLES  ),
        .GAME_RST_CYCLES ( GAME_RST_CYCLES )
    ) u_fsm (
        .clk_rom      ( clk_rom      ),
        .rst_n        ( rst_n        ),
        .pll_locked   ( pll_locked   ),
        .rst_req      ( rst_req      ),
        .soft_rst     ( soft_rst     ),
        .dwnld_busy   ( dwnld_busy   ),
        .ioctl_wr     ( ioctl_wr     ),
        .ioctl_cart   ( ioctl_cart   ),
        .timer_done   ( timer_done   ),
        .timer_load   ( timer_load   ),
        .timer_length ( timer_length ),
        .sdram_init   ( sdram_init   ),
        .rst          ( rst          ),
        .game_rst     ( game_rst     )
    );

    // led stays dark while the system is in reset
    led_driver #(
        .BLINK_FRAMES ( BLINK_FRAMES )
    ) u_led (
        .clk_rom    ( clk_rom    ),
        .rst_n      ( rst_n      ),
        .rst        ( rst        ),
        .lvbl       ( lvbl       ),
        .dwnld_busy ( dwnld_busy ),
        .osd_shown  ( osd_shown  ),
        .game_led   ( game_led   ),
        .led        ( led        )
    );

endmodule

//--- sim/board_supervisor_chk.sv
`timescale 1ns/1ps

module board_supervisor_chk import board_pkg::*; (
    input logic         clk_rom,
    input logic         rst_n,
    input logic         pll_locked,
    input reset_state_t state,
    input logic         sdram_init,
    input logic         rst,
    input logic         game_rst
);

    // memory must be ready before the system leaves reset
    a_sdram_holds_rst : assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        $fell(rst) |-> $past(state == ST_SYS_RST)
    ) else $error("rst released outside the system reset phase");

    // the game leaves reset only at the end of its own phase
    a_rst_holds_game : assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        $fell(game_rst) |-> $past(state == ST_GAME_RST)
    ) else $error("game_rst released outside the game reset phase");

    // losing the pll puts everything back into reset on the next cycle
    a_lock_loss : assert property (
        @(posedge clk_rom) disable iff (!rst_n)
        !pll_locked |=> (sdram_init && rst && game_rst)
    ) else $error("resets not all high one cycle after pll lock loss");

endmodule

bind reset_fsm board_supervisor_chk u_chk (
    .clk_rom    ( clk_rom    ),
    .rst_n      ( rst_n      ),
    .pll_locked ( pll_locked ),
    .state      ( state      ),
    .sdram_init ( sdram_init ),
    .rst        ( rst        ),
    .game_rst   ( game_rst   )
);

//--- sim/tb_board_supervisor.sv
`timescale 1ns/1ps

module tb_board_supervisor import board_pkg::*; ();

    localparam int         SEED        = 33432;
    localparam rst_cnt_t   INIT_LEN    = 16'd20;
    localparam rst_cnt_t   SYS_LEN     = 16'd8;
    localparam rst_cnt_t   GAME_LEN    = 16'd12;
    localparam frame_cnt_t BLINK_LEN   = 8'd3;
    localparam int         SOAK_CYCLES = 5000;
    localparam int         WAIT_LIMIT  = 400;

    logic      clk_rom = 1'b0;
    logic      rst_n;
    logic      pll_locked;
    logic      rst_req;
    logic      soft_rst;
    logic      dwnld_busy;
    logic      ioctl_wr;
    logic      ioctl_cart;
    logic      lvbl;
    logic      osd_shown;
    game_led_t game_led;
    logic      sdram_init;
    logic      rst;
    logic      game_rst;
    logic      led;

    // reference model state
    reset_state_t model_state;
    int           model_left;
    logic         model_lvbl_q;
    logic         model_fedge;
    logic         model_blink_q;
    logic         model_led;
    int           model_frames;

    // frame generator
    int    frame_pos;
    int    frame_len;
    string test_name;

    board_supervisor #(
        .INIT_CYCLES     ( INIT_LEN  ),
        .SYS_RST_CYCLES  ( SYS_LEN   ),
        .GAME_RST_CYCLES ( GAME_LEN  ),
        .BLINK_FRAMES    ( BLINK_LEN )
    ) i_dut (
        .clk_rom    ( clk_rom    ),
        .rst_n      ( rst_n      ),
        .pll_locked ( pll_locked ),
        .rst_req    ( rst_req    ),
        .soft_rst   ( soft_rst   ),
        .dwnld_busy ( dwnld_busy ),
        .ioctl_wr   ( ioctl_wr   ),
        .ioctl_cart ( ioctl_cart ),
        .lvbl       ( lvbl       ),
        .osd_shown  ( osd_shown  ),
        .game_led   ( game_led   ),
        .sdram_init ( sdram_init ),
        .rst        ( rst        ),
        .game_rst   ( game_rst   ),
        .led        ( led        )
    );

    always #4 clk_rom = ~clk_rom;

    function automatic int pick(int lo, int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    task automatic stop_on_failure(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_resets(string name, logic [2:0] exp, logic [2:0] act);
        if (act !== exp) begin
            stop_on_failure($sformatf("error %s resets expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_led(string name, logic exp, logic act);
        if (act !== exp) begin
            stop_on_failure($sformatf("error %s led expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            stop_on_failure($sformatf("error %s cycles expected %0d actual %0d", name, exp, act));
        end
    endtask

    // {sdram_init, rst, game_rst} for each phase
    function automatic logic [2:0] expected_resets(reset_state_t s);
        case (s)
            ST_WAIT_LOCK, ST_SDRAM_INIT: return 3'b111;
            ST_SYS_RST:                  return 3'b011;
            ST_GAME_RST, ST_ROM_LOAD:    return 3'b001;
            default:                     return 3'b000;
        endcase
    endfunction

    task automatic enter_phase(reset_state_t s, rst_cnt_t len);
        model_state = s;
        model_left  = int'(len);
    endtask

    // one clock edge of the reference model, using the inputs the dut sampled
    task automatic model_step();
        logic [2:0] held;
        logic       blink;
        logic       rom_wr;
        logic       past_init;
        if (!rst_n) begin
            model_state   = ST_WAIT_LOCK;
            model_left    = 0;
            model_lvbl_q  = 1'b0;
            model_fedge   = 1'b0;
            model_blink_q = 1'b0;
            model_frames  = 0;
            model_led     = 1'b0;
        end else begin
            held  = expected_resets(model_state);
            blink = dwnld_busy | game_led[1];
            // led sees this cycle's reset level and frame flag
            if (held[1]) begin
                model_led     = 1'b0;
                model_blink_q = 1'b0;
                model_frames  = 0;
            end else begin
                if (!blink) begin
                    model_frames = 0;
                    model_led    = osd_shown | game_led[0];
                end else if (!model_blink_q) begin
                    model_frames = 0;
                    model_led    = 1'b1;
                end else if (model_fedge) begin
                    if (model_frames + 1 >= int'(BLINK_LEN)) begin
                        model_frames = 0;
                        model_led    = ~model_led;
                    end else begin
                        model_frames = model_frames + 1;
                    end
                end
                model_blink_q = blink;
            end
            model_fedge  = model_lvbl_q & ~lvbl;
            model_lvbl_q = lvbl;

            rom_wr    = ioctl_wr & dwnld_busy & ~ioctl_cart;
            past_init = model_state inside {ST_SYS_RST, ST_GAME_RST, ST_RUN, ST_ROM_LOAD};
            if (!pll_locked) begin
                model_state = ST_WAIT_LOCK;
            end else if (rom_wr && past_init) begin
                model_state = ST_ROM_LOAD;
            end else if (rst_req && past_init) begin
                enter_phase(ST_SYS_RST, SYS_LEN);
            end else if (soft_rst && (model_state inside {ST_RUN, ST_GAME_RST})) begin
                enter_phase(ST_GAME_RST, GAME_LEN);
            end else if (model_state == ST_WAIT_LOCK) begin
                enter_phase(ST_SDRAM_INIT, INIT_LEN);
            end else if (model_state == ST_ROM_LOAD) begin
                if (!dwnld_busy) begin
                    enter_phase(ST_GAME_RST, GAME_LEN);
                end
            end else if (model_state != ST_RUN) begin
                // timed phase ends after its last cycle
                if (model_left > 1) begin
                    model_left = model_left - 1;
                end else if (model_state == ST_SDRAM_INIT) begin
                    enter_phase(ST_SYS_RST, SYS_LEN);
                end else if (model_state == ST_SYS_RST) begin
                    enter_phase(ST_GAME_RST, GAME_LEN);
                end else begin
                    model_state = ST_RUN;
                end
            end
        end
    endtask

    // advance one cycle, compare every output, then move the frame generator
    task automatic tick();
        @(negedge clk_rom);
        model_step();
        check_resets(test_name, expected_resets(model_state), {sdram_init, rst, game_rst});
        check_led(test_name, model_led, led);
        frame_pos = frame_pos + 1;
        if (frame_pos >= frame_len) begin
            frame_pos = 0;
            frame_len = pick(5, 12);
        end
        // two blanking lines at the start of each frame
        lvbl = (frame_pos >= 2);
    endtask

    task automatic drop_strobes();
        rst_req  = 1'b0;
        soft_rst = 1'b0;
        ioctl_wr = 1'b0;
    endtask

    task automatic run_cycles(int n);
        repeat (n) begin
            tick();
            drop_strobes();
        end
    endtask

    // counts how many cycles each reset stays high, starting with the sampling edge
    task automatic measure_release(output int n_sdram, output int n_rst, output int n_game);
        int cycles;
        bit done;
        n_sdram = -1;
        n_rst   = -1;
        n_game  = -1;
        cycles  = 0;
        done    = 1'b0;
        while (!done) begin
            tick();
            drop_strobes();
            if (n_sdram < 0 && !sdram_init) n_sdram = cycles;
            if (n_rst < 0 && !rst) n_rst = cycles;
            if (!game_rst) begin
                n_game = cycles;
                done   = 1'b1;
            end
            cycles = cycles + 1;
            if (!done && cycles > WAIT_LIMIT) begin
                stop_on_failure("timed out waiting for game_rst to be released");
            end
        end
    endtask

    task automatic drive_random();
        pll_locked = ($urandom % 400) != 0;
        rst_req    = ($urandom % 150) == 0;
        soft_rst   = ($urandom % 90) == 0;
        ioctl_wr   = ($urandom % 4) == 0;
        if (($urandom % 60) == 0) dwnld_busy = ~dwnld_busy;
        if (($urandom % 40) == 0) ioctl_cart = ~ioctl_cart;
        if (($urandom % 50) == 0) osd_shown = ~osd_shown;
        if (($urandom % 70) == 0) game_led = game_led_t'($urandom);
    endtask

    initial begin
        int n_sdram;
        int n_rst;
        int n_game;
        int hold;
        void'($urandom(SEED));
        rst_n      = 1'b0;
        pll_locked = 1'b0;
        rst_req    = 1'b0;
        soft_rst   = 1'b0;
        dwnld_busy = 1'b0;
        ioctl_wr   = 1'b0;
        ioctl_cart = 1'b0;
        lvbl       = 1'b1;
        osd_shown  = 1'b0;
        game_led   = '0;
        frame_pos  = 0;
        frame_len  = 8;
        test_name  = "reset";
        repeat (3) tick();
        rst_n = 1'b1;

        test_name = "power-up";
        run_cycles(pick(2, 10));
        pll_locked = 1'b1;
        measure_release(n_sdram, n_rst, n_game);
        check_count("power-up sdram_init", int'(INIT_LEN), n_sdram);
        check_count("power-up rst", int'(INIT_LEN) + int'(SYS_LEN), n_rst);
        check_count("power-up game_rst", int'(INIT_LEN) + int'(SYS_LEN) + int'(GAME_LEN), n_game);

        // drop lock while running, then again part way through the restart
        test_name  = "lock loss";
        pll_locked = 1'b0;
        tick();
        check_resets("lock loss in run", 3'b111, {sdram_init, rst, game_rst});
        run_cycles(pick(1, 4));
        pll_locked = 1'b1;
        run_cycles(pick(5, 35));
        pll_locked = 1'b0;
        tick();
        check_resets("lock loss in sequence", 3'b111, {sdram_init, rst, game_rst});
        run_cycles(pick(1, 4));
        pll_locked = 1'b1;
        measure_release(n_sdram, n_rst, n_game);
        check_count("relock sdram_init", int'(INIT_LEN), n_sdram);
        check_count("relock game_rst", int'(INIT_LEN) + int'(SYS_LEN) + int'(GAME_LEN), n_game);

        test_name = "request reset";
        osd_shown = 1'b1;
        run_cycles(2);
        check_led("osd before request", 1'b1, led);
        rst_req = 1'b1;
        measure_release(n_sdram, n_rst, n_game);
        check_count("request sdram_init", 0, n_sdram);
        check_count("request rst", int'(SYS_LEN), n_rst);
        check_count("request game_rst", int'(SYS_LEN) + int'(GAME_LEN), n_game);

        test_name = "soft reset";
        osd_shown = 1'b0;
        soft_rst  = 1'b1;
        measure_release(n_sdram, n_rst, n_game);
        check_count("soft rst", 0, n_rst);
        check_count("soft game_rst", int'(GAME_LEN), n_game);
        soft_rst = 1'b1;
        run_cycles(pick(2, 8));
        soft_rst = 1'b1;
        measure_release(n_sdram, n_rst, n_game);
        check_count("second soft rst", 0, n_rst);
        check_count("second soft game_rst", int'(GAME_LEN), n_game);

        test_name  = "rom download";
        dwnld_busy = 1'b1;
        ioctl_cart = 1'b0;
        run_cycles(pick(1, 4));
        ioctl_wr = 1'b1;
        run_cycles(1);
        check_resets("rom write", 3'b001, {sdram_init, rst, game_rst});
        hold = pick(40, 90);
        repeat (hold) begin
            ioctl_wr = ($urandom % 3) == 0;
            tick();
            check_resets("rom download held", 3'b001, {sdram_init, rst, game_rst});
        end
        ioctl_wr   = 1'b0;
        dwnld_busy = 1'b0;
        measure_release(n_sdram, n_rst, n_game);
        check_count("download rst", 0, n_rst);
        check_count("download game_rst", int'(GAME_LEN), n_game);

        test_name  = "cartridge write";
        dwnld_busy = 1'b1;
        ioctl_cart = 1'b1;
        repeat (pick(10, 20)) begin
            ioctl_wr = ($urandom % 2) == 0;
            tick();
            check_resets("cartridge write", 3'b000, {sdram_init, rst, game_rst});
        end
        ioctl_wr   = 1'b0;
        dwnld_busy = 1'b0;
        ioctl_cart = 1'b0;
        run_cycles(3);
        check_resets("after cartridge", 3'b000, {sdram_init, rst, game_rst});

        test_name = "led modes";
        osd_shown = 1'b1;
        game_led  = 2'b00;
        run_cycles(1);
        check_led("osd shown", 1'b1, led);
        osd_shown = 1'b0;
        game_led  = 2'b01;
        run_cycles(1);
        check_led("game led on", 1'b1, led);
        game_led = 2'b00;
        run_cycles(1);
        check_led("game led off", 1'b0, led);
        game_led = 2'b10;
        run_cycles(1);
        check_led("blink start", 1'b1, led);
        run_cycles(80);
        game_led = 2'b00;
        run_cycles(2);

        test_name = "random soak";
        repeat (SOAK_CYCLES) begin
            drive_random();
            tick();
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- sim.f
design/board_pkg.sv
design/reset_timer.sv
design/reset_fsm.sv
design/led_driver.sv
design/board_supervisor.sv
sim/board_supervisor_chk.sv
sim/tb_board_supervisor.sv

//--- run_sim.sh
#!/bin/sh
# build and run the board supervisor testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module tb_board_supervisor \
    --Mdir "$build_dir" \
    -o tb_board_supervisor \
    -f sim.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$("./$build_dir/tb_board_supervisor" 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi

echo "simulation ended without the pass message"
exit 1
